// File: src/ooo_pkg.sv
package ooo_pkg;

    localparam int DATA_W    = 32;
    localparam int AREG_W    = 5;
    localparam int PREG_W    = 6;  // room for 64 physical regs
    localparam int ROB_IDX_W = 4;  // room for 16 ROB entries
    localparam int NUM_AREG  = 1 << AREG_W;

    typedef logic [DATA_W-1:0]    data_t;
    typedef logic [AREG_W-1:0]    areg_t;
    typedef logic [PREG_W-1:0]    preg_t;
    typedef logic [ROB_IDX_W-1:0] rob_idx_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SLT
    } alu_op_e;

    // decoded op from the outside
    typedef struct packed {
        alu_op_e op;
        areg_t   rd;
        areg_t   rs1;
        areg_t   rs2;
        data_t   imm;
        logic    use_imm;  // rs2 replaced by imm
    } uop_t;

    // source operand, waits on tag until rdy
    typedef struct packed {
        logic  rdy;
        preg_t tag;
        data_t val;
    } operand_t;

    typedef struct packed {
        alu_op_e  op;
        preg_t    dest;
        rob_idx_t rob;
        operand_t src_a;
        operand_t src_b;
    } rs_entry_t;

    typedef struct packed {
        alu_op_e  op;
        data_t    a;
        data_t    b;
        preg_t    dest;
        rob_idx_t rob;
    } issue_t;

    typedef struct packed {
        preg_t    dest;
        rob_idx_t rob;
        data_t    value;
    } wb_t;

    typedef struct packed {
        areg_t rd;
        preg_t new_tag;
        preg_t old_tag;  // released at commit
    } rob_alloc_t;

    typedef struct packed {
        areg_t rd;
        data_t value;
    } commit_t;

endpackage

// File: src/rename_dispatch.sv
`timescale 1ns/100ps

module rename_dispatch #(
    parameter int NUM_PHYS = 48
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                dispatch_valid,
    input  ooo_pkg::uop_t       uop,
    input  logic                rs_full,
    input  logic                rob_full,
    input  ooo_pkg::rob_idx_t   rob_tail,
    input  logic                free_valid,
    input  ooo_pkg::preg_t      free_tag,
    input  logic                wb_valid,
    input  ooo_pkg::wb_t        wb,
    output logic                dispatch_ready,
    output logic                rs_write,
    output ooo_pkg::rs_entry_t  rs_entry,
    output logic                rob_alloc,
    output ooo_pkg::rob_alloc_t alloc
);
    import ooo_pkg::*;

    localparam int FL_DEPTH = NUM_PHYS - NUM_AREG;
    localparam int FL_PTR_W = $clog2(FL_DEPTH);
    localparam int FL_CNT_W = $clog2(FL_DEPTH + 1);

    preg_t               rat [NUM_AREG];
    data_t               prf [NUM_PHYS];
    logic [NUM_PHYS-1:0] prf_valid;

    preg_t               fl_mem [FL_DEPTH];
    logic [FL_PTR_W-1:0] fl_head;
    logic [FL_PTR_W-1:0] fl_tail;
    logic [FL_CNT_W-1:0] fl_cnt;

    logic     fire;
    logic     has_rd;
    logic     fl_pop;
    preg_t    new_tag;
    areg_t    src_r [2];
    operand_t src_op [2];

    assign dispatch_ready = !rs_full && !rob_full && (fl_cnt != '0);
    assign fire    = dispatch_valid && dispatch_ready;
    assign has_rd  = uop.rd != '0;
    assign fl_pop  = fire && has_rd;
    assign new_tag = fl_mem[fl_head];

    assign src_r[0] = uop.rs1;
    assign src_r[1] = uop.rs2;

    // capture value from PRF or same-cycle broadcast, else wait on tag
    always_comb begin
        for (int k = 0; k < 2; k++) begin
            src_op[k].tag = rat[src_r[k]];
            src_op[k].rdy = 1'b1;
            src_op[k].val = '0;
            if (src_r[k] == '0) begin
                src_op[k].tag = '0;  // x0 always zero
            end else if (prf_valid[src_op[k].tag]) begin
                src_op[k].val = prf[src_op[k].tag];
            end else if (wb_valid && wb.dest == src_op[k].tag) begin
                src_op[k].val = wb.value;
            end else begin
                src_op[k].rdy = 1'b0;
            end
        end
    end

    always_comb begin
        rs_entry.op    = uop.op;
        rs_entry.dest  = new_tag;
        rs_entry.rob   = rob_tail;
        rs_entry.src_a = src_op[0];
        rs_entry.src_b = src_op[1];
        if (uop.use_imm) begin
            rs_entry.src_b.rdy = 1'b1;
            rs_entry.src_b.tag = '0;
            rs_entry.src_b.val = uop.imm;
        end
    end

    assign rs_write      = fl_pop;  // writes to x0 bypass the RS
    assign rob_alloc     = fire;
    assign alloc.rd      = uop.rd;
    assign alloc.new_tag = has_rd ? new_tag : '0;
    assign alloc.old_tag = rat[uop.rd];

    // rat and register file
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_AREG; i++) begin
                rat[i] <= preg_t'(i);
            end
            for (int i = 0; i < NUM_PHYS; i++) begin
                prf[i]       <= '0;
                prf_valid[i] <= (i < NUM_AREG);
            end
        end else begin
            if (wb_valid) begin
                prf[wb.dest]       <= wb.value;
                prf_valid[wb.dest] <= 1'b1;
            end
            if (fl_pop) begin
                rat[uop.rd]        <= new_tag;
                prf_valid[new_tag] <= 1'b0;
            end
        end
    end

    // circular free list
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < FL_DEPTH; i++) begin
                fl_mem[i] <= preg_t'(NUM_AREG + i);
            end
            fl_head <= '0;
            fl_tail <= '0;
            fl_cnt  <= FL_CNT_W'(FL_DEPTH);
        end else begin
            if (fl_pop) begin
                fl_head <= (fl_head == FL_PTR_W'(FL_DEPTH - 1)) ? '0 : fl_head + 1'b1;
            end
            if (free_valid) begin
                fl_mem[fl_tail] <= free_tag;
                fl_tail <= (fl_tail == FL_PTR_W'(FL_DEPTH - 1)) ? '0 : fl_tail + 1'b1;
            end
            fl_cnt <= fl_cnt + FL_CNT_W'(free_valid) - FL_CNT_W'(fl_pop);
        end
    end

endmodule

// File: src/alu_rs.sv
`timescale 1ns/100ps

module alu_rs #(
    parameter int RS_DEPTH = 8
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               rs_write,
    input  ooo_pkg::rs_entry_t rs_entry,
    input  logic               wb_valid,
    input  ooo_pkg::wb_t       wb,
    output logic               rs_full,
    output logic               issue_valid,
    output ooo_pkg::issue_t    issue
);
    import ooo_pkg::*;

    localparam int IDX_W = $clog2(RS_DEPTH);
    localparam int CNT_W = $clog2(RS_DEPTH + 1);

    // entries kept in age order, oldest at index 0
    rs_entry_t        ent [RS_DEPTH];
    rs_entry_t        woke [RS_DEPTH];
    rs_entry_t        ent_nxt [RS_DEPTH];
    logic [CNT_W-1:0] cnt;
    logic [CNT_W-1:0] wr_idx;
    logic [IDX_W-1:0] sel;
    logic             found;

    function automatic operand_t wake(operand_t o, logic bc_valid, wb_t bc);
        operand_t res;
        res = o;
        if (bc_valid && !o.rdy && o.tag == bc.dest) begin
            res.rdy = 1'b1;
            res.val = bc.value;
        end
        return res;
    endfunction

    assign rs_full = cnt == CNT_W'(RS_DEPTH);

    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            woke[i]       = ent[i];
            woke[i].src_a = wake(ent[i].src_a, wb_valid, wb);
            woke[i].src_b = wake(ent[i].src_b, wb_valid, wb);
        end
    end

    // oldest ready entry wins
    always_comb begin
        sel   = '0;
        found = 1'b0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (i < int'(cnt) && ent[i].src_a.rdy && ent[i].src_b.rdy) begin
                sel   = IDX_W'(i);
                found = 1'b1;
            end
        end
    end

    assign issue_valid = found;
    assign issue.op    = ent[sel].op;
    assign issue.a     = ent[sel].src_a.val;
    assign issue.b     = ent[sel].src_b.val;
    assign issue.dest  = ent[sel].dest;
    assign issue.rob   = ent[sel].rob;

    assign wr_idx = cnt - CNT_W'(found);

    // collapse over the issued slot, append new entry at the end
    always_comb begin
        ent_nxt = woke;
        for (int i = 0; i < RS_DEPTH - 1; i++) begin
            if (found && i >= int'(sel)) begin
                ent_nxt[i] = woke[i + 1];
            end
        end
        if (rs_write) begin
            ent_nxt[IDX_W'(wr_idx)] = rs_entry;
        end
    end

    always_ff @(posedge clk) begin
        ent <= ent_nxt;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + CNT_W'(rs_write) - CNT_W'(found);
        end
    end

endmodule

// File: src/alu_exec.sv
`timescale 1ns/100ps

module alu_exec (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            issue_valid,
    input  ooo_pkg::issue_t issue,
    output logic            wb_valid,
    output ooo_pkg::wb_t    wb
);
    import ooo_pkg::*;

    data_t      result;
    logic [4:0] shamt;
    logic       lt;

    assign shamt = issue.b[4:0];
    assign lt    = $signed(issue.a) < $signed(issue.b);

    always_comb begin
        case (issue.op)
            ALU_ADD: result = issue.a + issue.b;
            ALU_SUB: result = issue.a - issue.b;
            ALU_AND: result = issue.a & issue.b;
            ALU_OR:  result = issue.a | issue.b;
            ALU_XOR: result = issue.a ^ issue.b;
            ALU_SLL: result = issue.a << shamt;
            ALU_SRL: result = issue.a >> shamt;
            ALU_SLT: result = {{(DATA_W-1){1'b0}}, lt};
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= issue_valid;
        end
    end

    // broadcast payload
    always_ff @(posedge clk) begin
        if (issue_valid) begin
            wb.dest  <= issue.dest;
            wb.rob   <= issue.rob;
            wb.value <= result;
        end
    end

endmodule

// File: src/reorder_buffer.sv
`timescale 1ns/100ps

module reorder_buffer #(
    parameter int ROB_DEPTH = 16
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                rob_alloc,
    input  ooo_pkg::rob_alloc_t alloc,
    input  logic                wb_valid,
    input  ooo_pkg::wb_t        wb,
    output logic                rob_full,
    output ooo_pkg::rob_idx_t   rob_tail,
    output logic                free_valid,
    output ooo_pkg::preg_t      free_tag,
    output logic                commit_valid,
    output ooo_pkg::commit_t    commit
);
    import ooo_pkg::*;

    localparam int CNT_W = ROB_IDX_W + 1;

    areg_t          rd_q [ROB_DEPTH];
    preg_t          old_q [ROB_DEPTH];
    data_t          val_q [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] done_q;
    rob_idx_t       head;
    rob_idx_t       tail;
    logic [CNT_W-1:0] cnt;

    function automatic rob_idx_t next_idx(rob_idx_t p);
        return (p == rob_idx_t'(ROB_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign rob_full = cnt == CNT_W'(ROB_DEPTH);
    assign rob_tail = tail;

    // head retires once done
    assign commit_valid = (cnt != '0) && done_q[head];
    assign commit.rd    = rd_q[head];
    assign commit.value = val_q[head];
    assign free_valid   = commit_valid && (rd_q[head] != '0);
    assign free_tag     = old_q[head];

    always_ff @(posedge clk) begin
        if (rob_alloc) begin
            rd_q[tail]  <= alloc.rd;
            old_q[tail] <= alloc.old_tag;
            val_q[tail] <= '0;  // x0 result
        end
        if (wb_valid) begin
            val_q[wb.rob] <= wb.value;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head   <= '0;
            tail   <= '0;
            cnt    <= '0;
            done_q <= '0;
        end else begin
            if (rob_alloc) begin
                done_q[tail] <= (alloc.rd == '0);  // nothing to wait for
                tail         <= next_idx(tail);
            end
            if (wb_valid) begin
                done_q[wb.rob] <= 1'b1;
            end
            if (commit_valid) begin
                done_q[head] <= 1'b0;
                head         <= next_idx(head);
            end
            cnt <= cnt + CNT_W'(rob_alloc) - CNT_W'(commit_valid);
        end
    end

endmodule

// File: src/ooo_core.sv
`timescale 1ns/100ps

module ooo_core #(
    parameter int NUM_PHYS  = 48,
    parameter int RS_DEPTH  = 8,
    parameter int ROB_DEPTH = 16
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             dispatch_valid,
    input  ooo_pkg::uop_t    uop,
    output logic             dispatch_ready,
    output logic             commit_valid,
    output ooo_pkg::commit_t commit
);
    import ooo_pkg::*;

    logic       rs_write;
    rs_entry_t  rs_entry;
    logic       rs_full;
    logic       rob_alloc;
    rob_alloc_t alloc;
    logic       rob_full;
    rob_idx_t   rob_tail;
    logic       free_valid;
    preg_t      free_tag;
    logic       issue_valid;
    issue_t     issue;
    logic       wb_valid;  // single result broadcast
    wb_t        wb;

    rename_dispatch #(.NUM_PHYS(NUM_PHYS)) u_rename_dispatch (
        .clk(clk), .arst_n(arst_n),
        .dispatch_valid(dispatch_valid), .uop(uop),
        .rs_full(rs_full), .rob_full(rob_full), .rob_tail(rob_tail),
        .free_valid(free_valid), .free_tag(free_tag),
        .wb_valid(wb_valid), .wb(wb),
        .dispatch_ready(dispatch_ready),
        .rs_write(rs_write), .rs_entry(rs_entry),
        .rob_alloc(rob_alloc), .alloc(alloc)
    );

    alu_rs #(.RS_DEPTH(RS_DEPTH)) u_alu_rs (
        .clk(clk), .arst_n(arst_n),
        .rs_write(rs_write), .rs_entry(rs_entry),
        .wb_valid(wb_valid), .wb(wb),
        .rs_full(rs_full), .issue_valid(issue_valid), .issue(issue)
    );

    alu_exec u_alu_exec (
        .clk(clk), .arst_n(arst_n),
        .issue_valid(issue_valid), .issue(issue),
        .wb_valid(wb_valid), .wb(wb)
    );

    reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) u_reorder_buffer (
        .clk(clk), .arst_n(arst_n),
        .rob_alloc(rob_alloc), .alloc(alloc),
        .wb_valid(wb_valid), .wb(wb),
        .rob_full(rob_full), .rob_tail(rob_tail),
        .free_valid(free_valid), .free_tag(free_tag),
        .commit_valid(commit_valid), .commit(commit)
    );

endmodule

// File: dv/tb_ooo_core.sv
`timescale 1ns/100ps

module tb_ooo_core;
    import ooo_pkg::*;

    localparam int NUM_PHYS = 48;
    localparam int TIMEOUT  = 200;  // cycles

    logic    clk;
    logic    arst_n;
    logic    dispatch_valid;
    uop_t    uop;
    logic    dispatch_ready;
    logic    commit_valid;
    commit_t commit;

    integer    seed;
    data_t     arch [NUM_AREG];  // in-order reference registers
    commit_t   exp_q [$];
    areg_t     last_rd;
    int        commit_cnt;
    int        write_cnt;
    int        stall_cycles;

    ooo_core #(.NUM_PHYS(NUM_PHYS), .RS_DEPTH(8), .ROB_DEPTH(16)) dut0 (
        .clk(clk), .arst_n(arst_n),
        .dispatch_valid(dispatch_valid), .uop(uop),
        .dispatch_ready(dispatch_ready),
        .commit_valid(commit_valid), .commit(commit)
    );

    always #20 clk = ~clk;

    task automatic stop_with_failure(input string why);
        $display("ERROR at %0t: %s", $time, why);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("FAIL time=%0t %s got=0x%0h expected=0x%0h", $time, name, got, exp);
            stop_with_failure("value mismatch");
        end
    endtask

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // reference ALU, straight from the operation list
    function automatic data_t model_alu(input alu_op_e op, input data_t a, input data_t b);
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[4:0];
            ALU_SRL: return a >> b[4:0];
            default: return ($signed(a) < $signed(b)) ? data_t'(1) : data_t'(0);
        endcase
    endfunction

    function automatic uop_t random_uop(input bit chain);
        uop_t u;
        u.op      = alu_op_e'(rand_below(8));
        u.rs1     = (rand_below(8) != 0) ? areg_t'(rand_below(8)) : areg_t'(rand_below(32));
        u.rs2     = (rand_below(8) != 0) ? areg_t'(rand_below(8)) : areg_t'(rand_below(32));
        u.imm     = $random(seed);
        u.use_imm = rand_below(2) != 0;
        if (rand_below(10) == 0) begin
            u.rd = '0;
        end else if (chain) begin
            u.rd  = areg_t'(1 + rand_below(3));
            u.rs1 = last_rd;  // long dependency chain
        end else begin
            u.rd = (rand_below(8) != 0) ? areg_t'(1 + rand_below(7)) : areg_t'(1 + rand_below(31));
        end
        return u;
    endfunction

    task automatic watch_commit();
        commit_t exp;
        if (commit_valid) begin
            if (exp_q.size() == 0) begin
                stop_with_failure("commit seen with no instruction outstanding");
            end else begin
                exp = exp_q.pop_front();
                check_value("commit.rd", commit.rd, exp.rd);
                check_value("commit.value", commit.value, exp.value);
                commit_cnt++;
            end
        end
    endtask

    // falling edge: sample outputs, then release the strobe
    task automatic next_cycle();
        @(negedge clk);
        watch_commit();
        dispatch_valid = 1'b0;
    endtask

    task automatic send(input uop_t u);
        data_t   a;
        data_t   b;
        data_t   res;
        commit_t exp;
        a   = arch[u.rs1];
        b   = u.use_imm ? u.imm : arch[u.rs2];
        res = model_alu(u.op, a, b);
        exp.rd    = u.rd;
        exp.value = (u.rd == '0) ? '0 : res;
        if (u.rd != '0) begin
            arch[u.rd] = res;
            last_rd    = u.rd;
            write_cnt++;
        end
        exp_q.push_back(exp);
        uop            = u;
        dispatch_valid = 1'b1;
    endtask

    task automatic send_when_ready(input uop_t u, input bit flood);
        int waited;
        waited = 0;
        next_cycle();
        while (!dispatch_ready || (!flood && rand_below(4) == 0)) begin
            if (!dispatch_ready) begin
                waited++;
                stall_cycles++;
            end
            if (waited > TIMEOUT) begin
                stop_with_failure("dispatch_ready stayed low past the timeout");
            end
            next_cycle();
        end
        send(u);
    endtask

    task automatic drain();
        int quiet;
        int seen;
        quiet = 0;
        while (exp_q.size() != 0) begin
            seen = commit_cnt;
            next_cycle();
            quiet = (commit_cnt == seen) ? quiet + 1 : 0;
            if (quiet > TIMEOUT) begin
                stop_with_failure("no commit within the timeout");
            end
        end
        repeat (10) next_cycle();  // catch duplicate commits
    endtask

    initial begin
        int    stall_before;
        uop_t  u;
        seed           = 27335;
        clk            = 1'b0;
        arst_n         = 1'b0;
        dispatch_valid = 1'b0;
        uop            = '0;
        last_rd        = 5'd1;
        commit_cnt     = 0;
        write_cnt      = 0;
        stall_cycles   = 0;
        for (int i = 0; i < NUM_AREG; i++) begin
            arch[i] = '0;
        end

        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        next_cycle();
        check_value("commit_valid", commit_valid, 1'b0);
        check_value("dispatch_ready", dispatch_ready, 1'b1);

        // mixed random stream
        for (int i = 0; i < 200; i++) begin
            send_when_ready(random_uop(1'b0), 1'b0);
        end

        // write to x0, then read x0 back
        u = '{op: ALU_ADD, rd: 5'd0, rs1: 5'd1, rs2: 5'd0, imm: 32'hdead_beef, use_imm: 1'b1};
        send_when_ready(u, 1'b1);
        u = '{op: ALU_OR, rd: 5'd5, rs1: 5'd0, rs2: 5'd0, imm: 32'h0, use_imm: 1'b0};
        send_when_ready(u, 1'b1);
        drain();

        // chains plus a strobe every ready cycle
        stall_before = stall_cycles;
        for (int i = 0; i < 100; i++) begin
            send_when_ready(random_uop(1'b1), 1'b1);
        end
        drain();

        check_value("backpressure_seen", stall_cycles > stall_before, 1'b1);
        check_value("writes_over_num_phys", write_cnt > NUM_PHYS, 1'b1);

        $display("TB PASSED");
        $finish;
    end

endmodule

// File: sim.f
src/ooo_pkg.sv
src/rename_dispatch.sv
src/alu_rs.sv
src/alu_exec.sv
src/reorder_buffer.sv
src/ooo_core.sv
dv/tb_ooo_core.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the ooo_core testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_ooo_core \
    -Mdir "$BUILD_DIR" -o sim_tb
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TB PASSED" "$LOG_FILE"; then
    echo "simulation passed"
    exit 0
fi
echo "pass message not found in $LOG_FILE"
exit 1
